//--- vlog.f
+incdir+include
hw/dvs_event_pkg.sv
hw/bin_store_pkg.sv
hw/bin_sequencer.sv
hw/histogram_bank.sv
hw/window_readout.sv
hw/time_surface_top.sv
tests/tb_time_surface.sv

//--- Makefile
# Verilator build and run of the pooling engine testbench

SIM      := verilator
SIMFLAGS := --binary --timing -j 0 -Wno-fatal
TOP      := tb_time_surface
FILELIST := vlog.f
OBJDIR   := obj_dir
PASS_MSG := test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# Fails unless the pass line shows up in the simulation output
test:
	$(SIM) $(SIMFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- tests/tb_time_surface.sv
`timescale 1ns/1ns
`default_nettype none

`include "binning_defines.svh"

module tb_time_surface
    import dvs_event_pkg::*;
    import bin_store_pkg::*;
();

    localparam int CELLS      = `GRID_SIZE * `GRID_SIZE;
    localparam int STREAM_LEN = `READOUT_BINS * CELLS;
    localparam int CNT_MAX    = (1 << `COUNT_BITS) - 1;
    localparam int CLK_HALF   = 20;
    localparam int DRIVE_DLY  = 2;

    // Event window opens after the head clear, closes well before the next start
    localparam int EVENT_LEAD   = 260;
    localparam int EVENT_BUDGET = `BIN_CYCLES - EVENT_LEAD - 40;
    localparam int SAT_HITS     = 320;

    // Wait limits in clock cycles
    localparam int START_LIMIT = 2 * `BIN_CYCLES + 400;
    localparam int DONE_LIMIT  = 2 * `BIN_CYCLES + STREAM_LEN;

    logic   clk;
    logic   rst;
    logic   event_valid;
    coord_t event_x;
    coord_t event_y;
    logic   readout_start;
    count_t readout_data;
    logic   readout_valid;

    // Reference ring of histograms and its head
    int          model_cnt [`NUM_BINS][CELLS];
    int          model_head;
    logic [31:0] lfsr;

    // Stream tracking, updated on the falling edge
    int   cycle_cnt;
    int   starts_seen;
    int   streams_done;
    int   last_start;
    int   since_start;
    int   beat_idx;
    int   data_checks;
    int   frame_checks;
    int   data_errors;
    int   frame_errors;
    logic aborted;

    time_surface_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .event_valid   (event_valid),
        .event_x       (event_x),
        .event_y       (event_y),
        .readout_start (readout_start),
        .readout_data  (readout_data),
        .readout_valid (readout_valid)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ============================
    // Stimulus helpers
    // ============================

    // Galois LFSR, one step per bit handed out
    function automatic int take_bits(input int n);
        int value;
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            if (lfsr[0])
                lfsr = (lfsr >> 1) ^ 32'h8020_0003;
            else
                lfsr = lfsr >> 1;
        end
        return value;
    endfunction

    // Inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // One event strobe, counted into the model head bin
    task automatic drive_event(input int x, input int y);
        int cell_idx;
        cell_idx    = (y + 8) * `GRID_SIZE + (x + 8);
        event_valid = 1'b1;
        event_x     = coord_t'(x);
        event_y     = coord_t'(y);
        if (model_cnt[model_head][cell_idx] < CNT_MAX)
            model_cnt[model_head][cell_idx]++;
    endtask

    // Random cells with random gaps of 0 to 3 idle cycles
    task automatic random_events(input int budget);
        int used;
        int gap;
        int xo;
        int yo;
        used = 0;
        gap  = take_bits(2);
        while (used + gap + 1 <= budget) begin
            xo = take_bits(4);
            yo = take_bits(4);
            drive_event(xo - 8, yo - 8);
            next_cycle();
            event_valid = 1'b0;
            repeat (gap) next_cycle();
            used += gap + 1;
            gap = take_bits(2);
        end
    endtask

    task automatic wait_start();
        int seen;
        int waited;
        seen   = starts_seen;
        waited = 0;
        while (!aborted && starts_seen == seen) begin
            next_cycle();
            waited++;
            if (waited > START_LIMIT) begin
                $display("timeout: no readout start pulse within %0d cycles", START_LIMIT);
                aborted = 1'b1;
            end
        end
    endtask

    task automatic wait_stream_done();
        int seen;
        int waited;
        seen   = streams_done;
        waited = 0;
        while (!aborted && streams_done == seen) begin
            next_cycle();
            waited++;
            if (waited > DONE_LIMIT) begin
                $display("timeout: readout stream did not complete within %0d cycles",
                         DONE_LIMIT);
                aborted = 1'b1;
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int chk_mark,
                               input int err_mark);
        $display("[%0d] %s: %0d checks, %0d errors", num, name,
                 data_checks - chk_mark, data_errors - err_mark);
    endtask

    // ============================
    // Stream monitor
    // ============================

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin : monitor
        logic exp_valid;
        int   blk_bin;
        int   cell_idx;
        int   c;
        cycle_cnt++;
        if (!rst) begin
            if (readout_start) begin
                frame_checks++;
                if (starts_seen > 0 && cycle_cnt - last_start != `BIN_CYCLES) begin
                    $display("error at %0t: start pulses %0d cycles apart, expected %0d",
                             $time, cycle_cnt - last_start, `BIN_CYCLES);
                    frame_errors++;
                end
                last_start  = cycle_cnt;
                starts_seen++;
                since_start = 0;
                beat_idx    = 0;
                // Ring advances and the new head starts empty
                model_head = (model_head + 1) % `NUM_BINS;
                for (c = 0; c < CELLS; c++)
                    model_cnt[model_head][c] = 0;
            end else if (starts_seen > 0) begin
                since_start++;
            end

            // Valid window is start + 2 up to start + 1281
            exp_valid = (starts_seen > 0) && (since_start >= 2) &&
                        (since_start < 2 + STREAM_LEN);
            frame_checks++;
            if (readout_valid !== exp_valid) begin
                $display("error at %0t: readout_valid is %b, expected %b",
                         $time, readout_valid, exp_valid);
                frame_errors++;
            end

            if (readout_valid === 1'b1 && exp_valid) begin
                // Oldest bin first, cells in address order
                blk_bin  = (model_head + `NUM_BINS - `READOUT_BINS + beat_idx / CELLS)
                           % `NUM_BINS;
                cell_idx = beat_idx % CELLS;
                data_checks++;
                if (readout_data !== count_t'(model_cnt[blk_bin][cell_idx])) begin
                    $display("error at %0t: bin %0d cell %0d read %0d, expected %0d",
                             $time, blk_bin, cell_idx, readout_data,
                             model_cnt[blk_bin][cell_idx]);
                    data_errors++;
                end
                beat_idx++;
                if (beat_idx == STREAM_LEN)
                    streams_done++;
            end
        end
    end

    // ============================
    // Test sequence
    // ============================
    initial begin : main
        int err_mark;
        int chk_mark;
        int sat_x;
        int sat_y;
        int b;
        int c;
        int i;

        rst          = 1'b1;
        event_valid  = 1'b0;
        event_x      = '0;
        event_y      = '0;
        lfsr         = 32'hd99d_03f9;
        model_head   = 0;
        cycle_cnt    = 0;
        starts_seen  = 0;
        streams_done = 0;
        last_start   = 0;
        since_start  = 0;
        beat_idx     = 0;
        data_checks  = 0;
        frame_checks = 0;
        data_errors  = 0;
        frame_errors = 0;
        aborted      = 1'b0;
        for (b = 0; b < `NUM_BINS; b++)
            for (c = 0; c < CELLS; c++)
                model_cnt[b][c] = 0;

        repeat (4) next_cycle();
        rst = 1'b0;

        // No events at all, every window must read back zero
        chk_mark = data_checks;
        err_mark = data_errors;
        repeat (3) wait_stream_done();
        report_test(1, "reset clears every bin", chk_mark, err_mark);

        // One bin of random events, seen as the newest block next time
        if (!aborted) begin
            chk_mark = data_checks;
            err_mark = data_errors;
            wait_start();
            repeat (EVENT_LEAD) next_cycle();
            random_events(EVENT_BUDGET);
            wait_stream_done();
            report_test(2, "event counting", chk_mark, err_mark);
        end

        // Twelve bins wrap the ring and reuse every bank
        if (!aborted) begin
            chk_mark = data_checks;
            err_mark = data_errors;
            for (i = 0; i < 12; i++) begin
                wait_start();
                if (aborted)
                    break;
                repeat (EVENT_LEAD) next_cycle();
                random_events(EVENT_BUDGET);
            end
            wait_stream_done();
            report_test(3, "chronological window across wrap", chk_mark, err_mark);
        end

        // Back-to-back hits on one cell run into the counter limit
        if (!aborted) begin
            chk_mark = data_checks;
            err_mark = data_errors;
            wait_start();
            repeat (EVENT_LEAD) next_cycle();
            sat_x = take_bits(4) - 8;
            sat_y = take_bits(4) - 8;
            for (i = 0; i < SAT_HITS; i++) begin
                drive_event(sat_x, sat_y);
                next_cycle();
            end
            event_valid = 1'b0;
            random_events(EVENT_BUDGET - SAT_HITS);
            wait_stream_done();
            report_test(4, "saturation and forwarding", chk_mark, err_mark);
        end

        // Every start pulse must have produced one full stream
        frame_checks++;
        if (streams_done != starts_seen) begin
            $display("error at %0t: %0d start pulses but %0d complete streams",
                     $time, starts_seen, streams_done);
            frame_errors++;
        end
        $display("[5] stream framing: %0d checks, %0d errors", frame_checks, frame_errors);

        $display("summary: %0d data checks, %0d framing checks, %0d errors",
                 data_checks, frame_checks, data_errors + frame_errors);
        if (aborted || data_errors + frame_errors != 0)
            $display("test failed");
        else
            $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/time_surface_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "binning_defines.svh"

module time_surface_top
    import dvs_event_pkg::*;
    import bin_store_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    // DVS event strobe and coordinates
    input  logic   event_valid,
    input  coord_t event_x,
    input  coord_t event_y,

    // Feature stream out
    output logic   readout_start,
    output count_t readout_data,
    output logic   readout_valid
);

    // ============================
    // Internal wiring
    // ============================

    // Sequencer to banks
    logic [`NUM_BINS-1:0] inc_en;
    cell_addr_t           inc_addr;
    logic [`NUM_BINS-1:0] clr_en;
    cell_addr_t           clr_addr;

    // Sequencer to readout
    bin_idx_t             head_bin;
    logic                 rollover;

    // Readout to banks, address is broadcast
    logic                 rd_en;
    cell_addr_t           rd_addr;

    // One read result per bank
    count_t               bank_rd_data [`NUM_BINS];

    // ============================
    // Bin timer and event routing
    // ============================
    bin_sequencer seq_i (
        .clk         (clk),
        .rst         (rst),
        .event_valid (event_valid),
        .event_x     (event_x),
        .event_y     (event_y),
        .inc_en      (inc_en),
        .inc_addr    (inc_addr),
        .clr_en      (clr_en),
        .clr_addr    (clr_addr),
        .head_bin    (head_bin),
        .rollover    (rollover)
    );

    // ============================
    // Ring of histogram banks
    // ============================
    for (genvar i = 0; i < `NUM_BINS; i++) begin : g_bank
        histogram_bank bank_i (
            .clk      (clk),
            .inc_en   (inc_en[i]),
            .inc_addr (inc_addr),
            .clr_en   (clr_en[i]),
            .clr_addr (clr_addr),
            .rd_en    (rd_en),
            .rd_addr  (rd_addr),
            .rd_data  (bank_rd_data[i])
        );
    end

    // Chronological window stream
    window_readout rdo_i (
        .clk           (clk),
        .rst           (rst),
        .rollover      (rollover),
        .head_bin      (head_bin),
        .bank_data     (bank_rd_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .readout_start (readout_start),
        .readout_data  (readout_data),
        .readout_valid (readout_valid)
    );

endmodule

`default_nettype wire

//--- hw/window_readout.sv
`timescale 1ns/1ns
`default_nettype none

`include "binning_defines.svh"

module window_readout
    import dvs_event_pkg::*;
    import bin_store_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // From the sequencer
    input  logic       rollover,
    input  bin_idx_t   head_bin,

    // Read results of every bank
    input  count_t     bank_data [`NUM_BINS],

    // Broadcast read address
    output logic       rd_en,
    output cell_addr_t rd_addr,

    // Feature stream
    output logic       readout_start,
    output count_t     readout_data,
    output logic       readout_valid
);

    localparam int CELLS = `GRID_SIZE * `GRID_SIZE;

    rd_state_t                     state;
    // Position of the bin inside the window, oldest first
    bin_idx_t                      rd_offset;
    cell_addr_t                    rd_cell;

    // Ring position of the block being read
    bin_idx_t                      ring_idx;

    // Bank select aligned with the bank read data
    bin_idx_t                      sel_bin;
    logic                          valid_d1;

    assign rd_en   = (state == rd_stream);
    assign rd_addr = rd_cell;

    // ============================
    // Chronological bin index
    // ============================

    // Oldest bin is head - READOUT_BINS, newest is head - 1
    // Wrap modulo NUM_BINS falls out of the ring index width
    assign ring_idx = bin_idx_t'(head_bin + (`NUM_BINS - `READOUT_BINS) + rd_offset);

    // ============================
    // Stream FSM
    // ============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= rd_idle;
            rd_offset     <= '0;
            rd_cell       <= '0;
            readout_start <= 1'b0;
        end else begin
            readout_start <= 1'b0;
            if (rollover) begin
                // First address goes out together with the start pulse
                state         <= rd_stream;
                rd_offset     <= '0;
                rd_cell       <= '0;
                readout_start <= 1'b1;
            end else if (state == rd_stream) begin
                rd_cell <= rd_cell + 1'b1;
                if (rd_cell == cell_addr_t'(CELLS - 1)) begin
                    if (rd_offset == bin_idx_t'(`READOUT_BINS - 1))
                        state <= rd_idle;
                    else
                        rd_offset <= rd_offset + 1'b1;
                end
            end
        end
    end

    // ============================
    // Output alignment
    // ============================

    // Bank read takes one cycle, output register one more
    always_ff @(posedge clk) begin
        sel_bin      <= ring_idx;
        readout_data <= bank_data[sel_bin];
    end

    // Valid follows the address by the same two cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_d1      <= 1'b0;
            readout_valid <= 1'b0;
        end else begin
            valid_d1      <= rd_en;
            readout_valid <= valid_d1;
        end
    end

endmodule

`default_nettype wire

//--- hw/histogram_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "binning_defines.svh"

module histogram_bank
    import dvs_event_pkg::*;
    import bin_store_pkg::*;
(
    input  logic       clk,

    // Increment port, read on inc_en and written one cycle later
    input  logic       inc_en,
    input  cell_addr_t inc_addr,

    // Clear port
    input  logic       clr_en,
    input  cell_addr_t clr_addr,

    // Readout port, data one cycle after address
    input  logic       rd_en,
    input  cell_addr_t rd_addr,
    output count_t     rd_data
);

    localparam int CELLS = `GRID_SIZE * `GRID_SIZE;

    // One counter per grid cell
    count_t     mem [CELLS];

    // Write stage of the increment pipeline
    logic       pend_valid;
    cell_addr_t pend_addr;
    count_t     pend_q;
    count_t     pend_sum;

    // Merged write port
    logic       wr_en;
    cell_addr_t wr_addr;
    count_t     wr_data;

    // ============================
    // Saturating increment
    // ============================

    // Hold at all ones instead of wrapping
    assign pend_sum = (pend_q == '1) ? pend_q : pend_q + 1'b1;

    // Clear wins over a pending increment
    assign wr_en   = clr_en | pend_valid;
    assign wr_addr = clr_en ? clr_addr : pend_addr;
    assign wr_data = clr_en ? '0 : pend_sum;

    always_ff @(posedge clk) begin
        pend_valid <= inc_en;
        if (inc_en) begin
            pend_addr <= inc_addr;
            // Forward the value being written this cycle
            // so back-to-back hits on one cell are not lost
            if (wr_en && wr_addr == inc_addr)
                pend_q <= wr_data;
            else
                pend_q <= mem[inc_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // ============================
    // Readout port
    // ============================
    always_ff @(posedge clk) begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- hw/bin_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "binning_defines.svh"

module bin_sequencer
    import dvs_event_pkg::*;
    import bin_store_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 event_valid,
    input  coord_t               event_x,
    input  coord_t               event_y,

    // Increment request, one bit per bank
    output logic [`NUM_BINS-1:0] inc_en,
    output cell_addr_t           inc_addr,

    // Clear write, one bit per bank
    output logic [`NUM_BINS-1:0] clr_en,
    output cell_addr_t           clr_addr,

    // Ring head and bin boundary pulse
    output bin_idx_t             head_bin,
    output logic                 rollover
);

    localparam int CELLS     = `GRID_SIZE * `GRID_SIZE;
    localparam int AXIS_BITS = $clog2(`GRID_SIZE);

    seq_state_t           state;
    // Set from reset until the first full clear is done
    logic                 init_clear;
    cell_addr_t           clr_cnt;
    bin_timer_t           bin_timer;
    logic                 timer_wrap;
    logic [`NUM_BINS-1:0] head_onehot;

    // Unsigned axis positions after centre shift
    logic [4:0]           map_x;
    logic [4:0]           map_y;
    cell_addr_t           event_cell;

    // ============================
    // Coordinate mapping
    // ============================

    // Shift -8..+7 up to 0..15
    assign map_x = event_x + 5'd8;
    assign map_y = event_y + 5'd8;

    // y above x gives y*16 + x
    assign event_cell = {map_y[AXIS_BITS-1:0], map_x[AXIS_BITS-1:0]};

    assign head_onehot = `NUM_BINS'(1) << head_bin;
    assign timer_wrap  = (bin_timer == bin_timer_t'(`BIN_CYCLES - 1));

    // Whole ring after reset, only the new head afterwards
    assign clr_en   = (state == seq_clear) ? (init_clear ? '1 : head_onehot) : '0;
    assign clr_addr = clr_cnt;

    // ============================
    // Timer, head and clear FSM
    // ============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= seq_clear;
            init_clear <= 1'b1;
            clr_cnt    <= '0;
            bin_timer  <= '0;
            head_bin   <= '0;
            rollover   <= 1'b0;
            inc_en     <= '0;
        end else begin
            rollover <= 1'b0;

            // Events only land in the head bank while it is not being cleared
            inc_en <= (event_valid && state == seq_run) ? head_onehot : '0;

            // Walk the clear address through every cell
            if (state == seq_clear) begin
                clr_cnt <= clr_cnt + 1'b1;
                if (clr_cnt == cell_addr_t'(CELLS - 1)) begin
                    state      <= seq_run;
                    init_clear <= 1'b0;
                end
            end

            // Timer stays at zero through the power-up clear
            if (!init_clear) begin
                if (timer_wrap) begin
                    bin_timer <= '0;
                    rollover  <= 1'b1;
                    state     <= seq_clear;
                    clr_cnt   <= '0;
                    if (head_bin == bin_idx_t'(`NUM_BINS - 1))
                        head_bin <= '0;
                    else
                        head_bin <= head_bin + 1'b1;
                end else begin
                    // keeps running through a bin clear
                    bin_timer <= bin_timer + 1'b1;
                end
            end
        end
    end

    // Cell index follows the event by one cycle
    always_ff @(posedge clk) begin
        inc_addr <= event_cell;
    end

endmodule

`default_nettype wire

//--- hw/bin_store_pkg.sv
`default_nettype none

`include "binning_defines.svh"

// ============================
// Bin storage and sequencing
// ============================

package bin_store_pkg;

    // Position in the ring of bins
    typedef logic [$clog2(`NUM_BINS)-1:0] bin_idx_t;

    // Saturating event counter of one cell
    typedef logic [`COUNT_BITS-1:0] count_t;

    // Cycle counter inside one bin period
    typedef logic [11:0] bin_timer_t;

    // Sequencer clears the head bank, then routes events into it
    typedef enum logic {
        seq_clear,
        seq_run
    } seq_state_t;

    // Readout waits for a rollover, then streams the window
    typedef enum logic {
        rd_idle,
        rd_stream
    } rd_state_t;

endpackage

`default_nettype wire

//--- hw/dvs_event_pkg.sv
`default_nettype none

`include "binning_defines.svh"

// ============================
// Incoming event description
// ============================

package dvs_event_pkg;

    // Signed coordinate relative to the grid centre
    // Range is -8 to +7 on each axis
    typedef logic signed [4:0] coord_t;

    // Cell index inside one bin
    // Upper half is the mapped y, lower half the mapped x
    typedef logic [2*$clog2(`GRID_SIZE)-1:0] cell_addr_t;

endpackage

`default_nettype wire

//--- include/binning_defines.svh
`ifndef BINNING_DEFINES_SVH
`define BINNING_DEFINES_SVH

// ============================
// Spatial grid
// ============================

// Cells per grid side, spanned by a 4-bit coordinate field
`define GRID_SIZE 16

// ============================
// Time bins
// ============================

// Histograms held in the ring
`define NUM_BINS 8

// Completed bins streamed per readout, kept below NUM_BINS
`define READOUT_BINS 5

// Width of one cell counter
`define COUNT_BITS 8

// Clock cycles per bin
// Must cover one bin clear plus a full readout stream
`define BIN_CYCLES 2000

`endif
